//--- hw/stepper_config.svh
`ifndef STEPPER_CONFIG_SVH
`define STEPPER_CONFIG_SVH

// data ram window
`define STEPPER_RAM_BASE 32'h0000_1000
`define STEPPER_RAM_WORDS 1024

// io register window
`define STEPPER_IO_BASE 32'h1000_0000
`define STEPPER_IO_SPAN 32'h0000_0040

// step high time in clocks
`define STEPPER_STEP_PULSE 4

// shorter periods get clamped up to this
`define STEPPER_PERIOD_MIN 8

// sck divider after reset
`define STEPPER_SPI_DIV_RESET 8'd3

`endif

//--- hw/bus_pkg.sv
package bus_pkg;

  // host bus word and address
  typedef logic [31:0] bus_addr_t;
  typedef logic [31:0] bus_data_t;

  // one bit per byte lane, zero means read
  typedef logic [3:0] bus_strb_t;

  // word offsets inside the io window
  typedef enum logic [5:0] {
    spi_tx_lower = 6'h00,
    // only bits 7..0 are kept
    spi_tx_upper = 6'h04,
    spi_rx_lower = 6'h08,
    spi_rx_upper = 6'h0C,
    // bit 0 start or busy, bits 15..8 divider
    spi_ctrl     = 6'h10,
    step_period  = 6'h14,
    // a write loads and starts a move
    step_count   = 6'h18,
    // bit 0 direction, bit 1 driver enable
    step_ctrl    = 6'h1C,
    step_status  = 6'h20
  } io_reg_e;

endpackage

//--- hw/motor_pkg.sv
package motor_pkg;

  // driver frame length in bits
  localparam int unsigned spi_frame_bits = 40;

  typedef logic [spi_frame_bits-1:0] spi_frame_t;

  // sck half period is div + 1 clocks
  typedef logic [7:0] spi_div_t;

  // counts half periods, lead-in plus two per bit
  typedef logic [6:0] spi_half_t;

  // steps still to go
  typedef logic [15:0] step_count_t;

  // clocks between step rising edges
  typedef logic [15:0] step_period_t;

endpackage

//--- hw/bus_decoder.sv
`timescale 1ns/1ps
`include "stepper_config.svh"

module bus_decoder import bus_pkg::*; (
  input  logic      clk_25mhz,
  input  logic      rst_n,
  input  logic      mem_valid,
  input  bus_addr_t mem_addr,
  input  logic      ram_ready,
  input  logic      io_ready,
  input  bus_data_t ram_rdata,
  input  bus_data_t io_rdata,
  output logic      mem_ready,
  output bus_data_t mem_rdata,
  output logic      ram_sel,
  output logic      io_sel,
  output logic      bus_fault
);

  // window bounds, upper bound exclusive
  localparam bus_addr_t ram_lo = `STEPPER_RAM_BASE;
  localparam bus_addr_t ram_hi = `STEPPER_RAM_BASE + 4 * `STEPPER_RAM_WORDS;
  localparam bus_addr_t io_lo = `STEPPER_IO_BASE;
  localparam bus_addr_t io_hi = `STEPPER_IO_BASE + `STEPPER_IO_SPAN;

  logic ram_hit;
  logic io_hit;
  logic accept;
  logic busy;
  logic fault_sel;
  logic fault_ready;

  assign ram_hit = (mem_addr >= ram_lo) && (mem_addr < ram_hi);
  assign io_hit = (mem_addr >= io_lo) && (mem_addr < io_hi);

  // new request only when nothing is outstanding
  // valid is still high on the ready edge, so busy holds through it
  assign accept = mem_valid && !busy;

  always_ff @(posedge clk_25mhz) begin
    if (!rst_n) begin
      busy        <= 1'b0;
      ram_sel     <= 1'b0;
      io_sel      <= 1'b0;
      fault_sel   <= 1'b0;
      fault_ready <= 1'b0;
    end else begin
      // one-hot select, one cycle wide
      ram_sel   <= accept && ram_hit;
      io_sel    <= accept && io_hit;
      fault_sel <= accept && !ram_hit && !io_hit;
      // unmapped access answers with the same latency as a target
      fault_ready <= fault_sel;
      if (accept) begin
        busy <= 1'b1;
      end else if (mem_ready) begin
        busy <= 1'b0;
      end
    end
  end

  assign bus_fault = fault_ready;
  assign mem_ready = ram_ready | io_ready | fault_ready;

  // fault and idle return zero
  always_comb begin
    if (ram_ready) begin
      mem_rdata = ram_rdata;
    end else if (io_ready) begin
      mem_rdata = io_rdata;
    end else begin
      mem_rdata = '0;
    end
  end

endmodule

//--- hw/sram.sv
`timescale 1ns/1ps
`include "stepper_config.svh"

module sram import bus_pkg::*; #(
  parameter int unsigned depth_words = `STEPPER_RAM_WORDS
) (
  input  logic      clk_25mhz,
  input  logic      rst_n,
  input  logic      sel,
  input  bus_addr_t addr,
  input  bus_data_t wdata,
  input  bus_strb_t wstrb,
  output logic      ready,
  output bus_data_t rdata
);

  localparam int unsigned addr_bits = $clog2(depth_words);

  bus_data_t mem [depth_words];
  logic [addr_bits-1:0] idx;

  // word index, byte offset bits dropped
  assign idx = addr[addr_bits+1:2];

  // storage and read port
  always_ff @(posedge clk_25mhz) begin
    if (sel) begin
      // only the strobed lanes change
      for (int lane = 0; lane < 4; lane++) begin
        if (wstrb[lane]) begin
          mem[idx][8*lane +: 8] <= wdata[8*lane +: 8];
        end
      end
      // old word comes back on a write, the bus ignores it
      rdata <= mem[idx];
    end
  end

  // answer on the edge after select
  always_ff @(posedge clk_25mhz) begin
    if (!rst_n) begin
      ready <= 1'b0;
    end else begin
      ready <= sel;
    end
  end

endmodule

//--- hw/spi_master.sv
`timescale 1ns/1ps

module spi_master import motor_pkg::*; (
  input  logic       clk_25mhz,
  input  logic       rst_n,
  input  logic       start,
  input  spi_frame_t tx,
  input  spi_div_t   div,
  input  logic       miso,
  output logic       busy,
  output spi_frame_t rx,
  output logic       sck,
  output logic       mosi,
  output logic       cs_n
);

  // lead-in half, then high and low halves per bit
  localparam spi_half_t last_half = spi_half_t'(2 * spi_frame_bits);

  spi_div_t   div_q;
  spi_div_t   div_cnt;
  spi_half_t  half_cnt;
  spi_frame_t shreg;
  logic       miso_q;
  logic       half_end;

  assign half_end = busy && (div_cnt == div_q);

  // control path
  always_ff @(posedge clk_25mhz) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      cs_n     <= 1'b1;
      sck      <= 1'b0;
      div_q    <= '0;
      div_cnt  <= '0;
      half_cnt <= '0;
      rx       <= '0;
    end else if (!busy) begin
      if (start) begin
        busy     <= 1'b1;
        cs_n     <= 1'b0;
        div_q    <= div;
        div_cnt  <= '0;
        half_cnt <= '0;
      end
    end else if (half_end) begin
      div_cnt  <= '0;
      half_cnt <= half_cnt + spi_half_t'(1);
      if (half_cnt == last_half) begin
        // trailing half done, release the driver
        busy <= 1'b0;
        cs_n <= 1'b1;
        rx   <= shreg;
      end else begin
        sck <= ~sck;
      end
    end else begin
      div_cnt <= div_cnt + spi_div_t'(1);
    end
  end

  // data path, msb first
  always_ff @(posedge clk_25mhz) begin
    if (!busy && start) begin
      shreg <= tx;
    end else if (half_end && (half_cnt != last_half)) begin
      if (!sck) begin
        // rising sck edge, sample
        miso_q <= miso;
      end else begin
        // falling sck edge, next bit out and sample in
        shreg <= {shreg[spi_frame_bits-2:0], miso_q};
      end
    end
  end

  // line parked low outside a frame
  assign mosi = shreg[spi_frame_bits-1] & ~cs_n;

endmodule

//--- hw/step_generator.sv
`timescale 1ns/1ps
`include "stepper_config.svh"

module step_generator import motor_pkg::*; (
  input  logic         clk_25mhz,
  input  logic         rst_n,
  input  logic         load,
  input  step_count_t  count_in,
  input  step_period_t period,
  input  logic         enable,
  output logic         step,
  output step_count_t  remaining
);

  localparam step_period_t period_min = step_period_t'(`STEPPER_PERIOD_MIN);
  localparam int unsigned pulse_bits = $clog2(`STEPPER_STEP_PULSE + 1);
  localparam logic [pulse_bits-1:0] pulse_last = pulse_bits'(`STEPPER_STEP_PULSE - 1);

  step_period_t eff_period;
  step_period_t per_cnt;
  logic [pulse_bits-1:0] pulse_cnt;
  logic pulse_on;
  logic fire;

  // too short a period would overlap the pulses
  assign eff_period = (period < period_min) ? period_min : period;

  // a load cycle restarts the period, no step on it
  assign fire = enable && !load && (remaining != '0) &&
                (per_cnt == eff_period - step_period_t'(1));

  always_ff @(posedge clk_25mhz) begin
    if (!rst_n) begin
      remaining <= '0;
      per_cnt   <= '0;
      pulse_on  <= 1'b0;
      pulse_cnt <= '0;
    end else if (!enable) begin
      // abort the move
      remaining <= '0;
      per_cnt   <= '0;
      pulse_on  <= 1'b0;
      pulse_cnt <= '0;
    end else begin
      // fixed-width high time
      if (fire) begin
        pulse_on  <= 1'b1;
        pulse_cnt <= pulse_last;
      end else if (pulse_on) begin
        if (pulse_cnt == '0) begin
          pulse_on <= 1'b0;
        end else begin
          pulse_cnt <= pulse_cnt - 1'b1;
        end
      end
      // period timer and step count
      if (load) begin
        remaining <= count_in;
        per_cnt   <= '0;
      end else if (fire) begin
        remaining <= remaining - step_count_t'(1);
        per_cnt   <= '0;
      end else if (remaining != '0) begin
        per_cnt <= per_cnt + step_period_t'(1);
      end
    end
  end

  // pin drops in the same cycle enable goes away
  assign step = pulse_on && enable;

endmodule

//--- hw/io_block.sv
`timescale 1ns/1ps
`include "stepper_config.svh"

module io_block
  import bus_pkg::*;
  import motor_pkg::*;
(
  input  logic      clk_25mhz,
  input  logic      rst_n,
  input  logic      sel,
  input  bus_addr_t addr,
  input  bus_data_t wdata,
  input  bus_strb_t wstrb,
  input  logic      spi_miso,
  output logic      ready,
  output bus_data_t rdata,
  output logic      spi_sck,
  output logic      spi_mosi,
  output logic      spi_cs_n,
  output logic      step,
  output logic      dir,
  output logic      drv_en_n
);

  logic [5:0]   offset;
  logic         wr_en;
  bus_data_t    rd_word;
  logic [31:0]  tx_lo_q;
  logic [7:0]   tx_hi_q;
  spi_div_t     div_q;
  step_period_t period_q;
  step_count_t  count_q;
  logic [1:0]   ctrl_q;
  logic         start_q;
  logic         load_q;
  spi_frame_t   spi_rx;
  logic         spi_busy;
  step_count_t  step_remaining;

  assign offset = addr[5:0];
  // registers only take full-word writes
  assign wr_en = sel && (wstrb == 4'hF);

  always_ff @(posedge clk_25mhz) begin
    if (!rst_n) begin
      tx_lo_q  <= '0;
      tx_hi_q  <= '0;
      div_q    <= `STEPPER_SPI_DIV_RESET;
      period_q <= '0;
      count_q  <= '0;
      ctrl_q   <= '0;
      start_q  <= 1'b0;
      load_q   <= 1'b0;
      ready    <= 1'b0;
    end else begin
      // one-cycle strobes
      start_q <= 1'b0;
      load_q  <= 1'b0;
      ready   <= sel;
      if (wr_en) begin
        case (offset)
          spi_tx_lower: tx_lo_q <= wdata;
          spi_tx_upper: tx_hi_q <= wdata[7:0];
          spi_ctrl: begin
            div_q   <= wdata[15:8];
            start_q <= wdata[0];
          end
          step_period: period_q <= wdata[15:0];
          step_count: begin
            count_q <= wdata[15:0];
            load_q  <= 1'b1;
          end
          step_ctrl: ctrl_q <= wdata[1:0];
          default: ;
        endcase
      end
    end
  end

  // read mux, unknown offsets give zero
  always_comb begin
    case (offset)
      spi_tx_lower: rd_word = tx_lo_q;
      spi_tx_upper: rd_word = {24'h0, tx_hi_q};
      spi_rx_lower: rd_word = spi_rx[31:0];
      spi_rx_upper: rd_word = {24'h0, spi_rx[39:32]};
      spi_ctrl:     rd_word = {16'h0, div_q, 7'h0, spi_busy};
      step_period:  rd_word = {16'h0, period_q};
      step_count:   rd_word = {16'h0, count_q};
      step_ctrl:    rd_word = {30'h0, ctrl_q};
      step_status:  rd_word = {16'h0, step_remaining};
      default:      rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_25mhz) begin
    if (sel) begin
      rdata <= rd_word;
    end
  end

  assign dir = ctrl_q[0];
  assign drv_en_n = ~ctrl_q[1];

  spi_master spi_master_i (
    .clk_25mhz (clk_25mhz),
    .rst_n     (rst_n),
    .start     (start_q),
    .tx        ({tx_hi_q, tx_lo_q}),
    .div       (div_q),
    .miso      (spi_miso),
    .busy      (spi_busy),
    .rx        (spi_rx),
    .sck       (spi_sck),
    .mosi      (spi_mosi),
    .cs_n      (spi_cs_n)
  );

  step_generator step_generator_i (
    .clk_25mhz (clk_25mhz),
    .rst_n     (rst_n),
    .load      (load_q),
    .count_in  (count_q),
    .period    (period_q),
    .enable    (ctrl_q[1]),
    .step      (step),
    .remaining (step_remaining)
  );

endmodule

//--- hw/stepper_top.sv
`timescale 1ns/1ps

module stepper_top import bus_pkg::*; (
  input  logic      clk_25mhz,
  input  logic      rst_n,
  // host bus
  input  logic      mem_valid,
  input  bus_addr_t mem_addr,
  input  bus_data_t mem_wdata,
  input  bus_strb_t mem_wstrb,
  output logic      mem_ready,
  output bus_data_t mem_rdata,
  output logic      bus_fault,
  // motor driver spi
  input  logic      spi_miso,
  output logic      spi_sck,
  output logic      spi_mosi,
  output logic      spi_cs_n,
  // step and direction pins
  output logic      step,
  output logic      dir,
  output logic      drv_en_n
);

  logic      ram_sel;
  logic      io_sel;
  logic      ram_ready;
  logic      io_ready;
  bus_data_t ram_rdata;
  bus_data_t io_rdata;

  bus_decoder bus_decoder_i (
    .clk_25mhz (clk_25mhz),
    .rst_n     (rst_n),
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .ram_ready (ram_ready),
    .io_ready  (io_ready),
    .ram_rdata (ram_rdata),
    .io_rdata  (io_rdata),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata),
    .ram_sel   (ram_sel),
    .io_sel    (io_sel),
    .bus_fault (bus_fault)
  );

  // data ram
  sram sram_i (
    .clk_25mhz (clk_25mhz),
    .rst_n     (rst_n),
    .sel       (ram_sel),
    .addr      (mem_addr),
    .wdata     (mem_wdata),
    .wstrb     (mem_wstrb),
    .ready     (ram_ready),
    .rdata     (ram_rdata)
  );

  io_block io_block_i (
    .clk_25mhz (clk_25mhz),
    .rst_n     (rst_n),
    .sel       (io_sel),
    .addr      (mem_addr),
    .wdata     (mem_wdata),
    .wstrb     (mem_wstrb),
    .spi_miso  (spi_miso),
    .ready     (io_ready),
    .rdata     (io_rdata),
    .spi_sck   (spi_sck),
    .spi_mosi  (spi_mosi),
    .spi_cs_n  (spi_cs_n),
    .step      (step),
    .dir       (dir),
    .drv_en_n  (drv_en_n)
  );

endmodule

//--- tb/stepper_top_properties.sv
`timescale 1ns/1ps

module stepper_top_properties (
  input logic clk_25mhz,
  input logic rst_n,
  input logic mem_valid,
  input logic mem_ready,
  input logic spi_sck,
  input logic spi_cs_n,
  input logic step,
  input logic drv_en_n
);

  // ready only answers a held request
  ready_needs_valid: assert property (
    @(posedge clk_25mhz) disable iff (!rst_n) mem_ready |-> mem_valid
  ) else $error("mem_ready high without mem_valid");

  // single-cycle ready
  ready_one_cycle: assert property (
    @(posedge clk_25mhz) disable iff (!rst_n) mem_ready |=> !mem_ready
  ) else $error("mem_ready high on two cycles in a row");

  // mode 0, sck parked low outside a frame
  sck_idle_low: assert property (
    @(posedge clk_25mhz) disable iff (!rst_n) spi_cs_n |-> !spi_sck
  ) else $error("spi_sck high while spi_cs_n is high");

  // no step while disabled and no stale pulse on the first enabled cycle
  step_needs_enable: assert property (
    @(posedge clk_25mhz) disable iff (!rst_n) (drv_en_n || $past(drv_en_n)) |-> !step
  ) else $error("step high while driver is disabled or just enabled");

endmodule

bind stepper_top stepper_top_properties stepper_top_properties_i (.*);

//--- tb/stepper_tb.sv
`timescale 1ns/1ps
`include "stepper_config.svh"

module stepper_tb
  import bus_pkg::*;
  import motor_pkg::*;
();

  localparam int unsigned ram_words = `STEPPER_RAM_WORDS;
  localparam int unsigned ready_limit = 20;

  logic      clk_25mhz;
  logic      rst_n;
  logic      mem_valid;
  bus_addr_t mem_addr;
  bus_data_t mem_wdata;
  bus_strb_t mem_wstrb;
  logic      mem_ready;
  bus_data_t mem_rdata;
  logic      bus_fault;
  logic      spi_sck;
  logic      spi_mosi;
  logic      spi_cs_n;
  logic      step;
  logic      dir;
  logic      drv_en_n;

  integer    seed;
  bus_data_t ram_model [ram_words];
  int        sck_rises;
  int        step_rises;
  logic      sck_prev;
  logic      step_prev;

  // miso looped back from mosi
  stepper_top stepper_top_i (
    .clk_25mhz (clk_25mhz),
    .rst_n     (rst_n),
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata),
    .bus_fault (bus_fault),
    .spi_miso  (spi_mosi),
    .spi_sck   (spi_sck),
    .spi_mosi  (spi_mosi),
    .spi_cs_n  (spi_cs_n),
    .step      (step),
    .dir       (dir),
    .drv_en_n  (drv_en_n)
  );

  // 25 MHz
  always #20 clk_25mhz = ~clk_25mhz;

  // edge counters, sampled mid-cycle where pins are settled
  always @(negedge clk_25mhz) begin
    if (spi_sck === 1'b1 && sck_prev === 1'b0 && spi_cs_n === 1'b0) begin
      sck_rises++;
    end
    if (step === 1'b1 && step_prev === 1'b0) begin
      step_rises++;
    end
    sck_prev = spi_sck;
    step_prev = step;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_word(input bus_data_t got, input bus_data_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("FAIL %0t ns: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_frame(input spi_frame_t got, input spi_frame_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("FAIL %0t ns: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_count(input step_count_t got, input step_count_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("FAIL %0t ns: %s got %0d expected %0d", $time, what, got, exp));
    end
  endtask

  function automatic bus_addr_t io_addr(input io_reg_e off);
    return `STEPPER_IO_BASE + bus_addr_t'(off);
  endfunction

  // memory map as documented
  function automatic logic is_mapped(input bus_addr_t a);
    logic in_ram;
    logic in_io;
    in_ram = (a >= `STEPPER_RAM_BASE) && (a < `STEPPER_RAM_BASE + 4 * ram_words);
    in_io = (a >= `STEPPER_IO_BASE) && (a < `STEPPER_IO_BASE + `STEPPER_IO_SPAN);
    return in_ram || in_io;
  endfunction

  // initial ram contents, spread over the whole address
  function automatic bus_data_t fill_word(input bus_addr_t a);
    return (a * 32'h9E37_79B1) ^ 32'hC3A5_5A3C;
  endfunction

  // byte-lane write merge
  function automatic bus_data_t merge_bytes(input bus_data_t old, input bus_data_t wdata,
                                            input bus_strb_t strb);
    bus_data_t res;
    res = old;
    for (int lane = 0; lane < 4; lane++) begin
      if (strb[lane]) begin
        res[8*lane +: 8] = wdata[8*lane +: 8];
      end
    end
    return res;
  endfunction

  // one bus access, ready expected two edges after valid
  task automatic bus_xfer(input bus_addr_t addr, input bus_data_t wdata, input bus_strb_t strb,
                          output bus_data_t rdata, output logic fault);
    int edges;
    edges = 0;
    @(posedge clk_25mhz);
    #2;
    mem_valid = 1'b1;
    mem_addr = addr;
    mem_wdata = wdata;
    mem_wstrb = strb;
    do begin
      @(posedge clk_25mhz);
      #1;
      edges++;
      if (edges > ready_limit) begin
        abort_run("timeout: the bus never raised mem_ready");
      end
    end while (mem_ready !== 1'b1);
    rdata = mem_rdata;
    fault = bus_fault;
    check_word(bus_data_t'(edges), 32'd2, "bus latency in edges");
    // valid held through the ready cycle
    @(posedge clk_25mhz);
    #2;
    mem_valid = 1'b0;
  endtask

  task automatic reg_write(input bus_addr_t addr, input bus_data_t data);
    bus_data_t unused;
    logic fault;
    bus_xfer(addr, data, 4'hF, unused, fault);
    check_word(bus_data_t'(fault), 32'd0, "bus_fault on mapped write");
  endtask

  task automatic reg_read(input bus_addr_t addr, output bus_data_t data);
    logic fault;
    bus_xfer(addr, 32'h0, 4'h0, data, fault);
    check_word(bus_data_t'(fault), 32'd0, "bus_fault on mapped read");
  endtask

  task automatic ram_fill();
    bus_addr_t addr;
    for (int i = 0; i < ram_words; i++) begin
      addr = `STEPPER_RAM_BASE + 4 * i;
      ram_model[i] = fill_word(addr);
      reg_write(addr, ram_model[i]);
    end
  endtask

  task automatic ram_compare_all();
    bus_data_t got;
    for (int i = 0; i < ram_words; i++) begin
      reg_read(`STEPPER_RAM_BASE + 4 * i, got);
      check_word(got, ram_model[i], "ram contents");
    end
  endtask

  // mixed reads and strobed writes, strobe zero is a read
  task automatic ram_random_test();
    int        idx;
    bus_addr_t addr;
    bus_data_t data;
    bus_strb_t strb;
    bus_data_t got;
    logic      fault;
    for (int n = 0; n < 200; n++) begin
      idx = $unsigned($random(seed)) % ram_words;
      addr = `STEPPER_RAM_BASE + 4 * idx;
      data = $random(seed);
      strb = ($random(seed) & 1) ? bus_strb_t'($random(seed)) : 4'h0;
      bus_xfer(addr, data, strb, got, fault);
      check_word(bus_data_t'(fault), 32'd0, "bus_fault on ram access");
      if (strb == 4'h0) begin
        check_word(got, ram_model[idx], "ram read data");
      end else begin
        ram_model[idx] = merge_bytes(ram_model[idx], data, strb);
      end
    end
  endtask

  task automatic unmapped_test();
    bus_addr_t addr;
    bus_data_t got;
    logic      fault;
    for (int n = 0; n < 24; n++) begin
      // window edges first
      case (n)
        0: addr = `STEPPER_RAM_BASE - 4;
        1: addr = `STEPPER_RAM_BASE + 4 * ram_words;
        2: addr = `STEPPER_IO_BASE + `STEPPER_IO_SPAN;
        default: begin
          addr = $random(seed);
          if (is_mapped(addr)) begin
            addr = addr ^ 32'h8000_0000;
          end
        end
      endcase
      bus_xfer(addr, $random(seed), (n % 2) ? 4'hF : 4'h0, got, fault);
      check_word(got, 32'h0, "unmapped read data");
      check_word(bus_data_t'(fault), 32'd1, "bus_fault on unmapped access");
    end
    ram_compare_all();
  endtask

  task automatic wait_cs(input logic level, input string what);
    int cycles;
    cycles = 0;
    while (spi_cs_n !== level) begin
      @(posedge clk_25mhz);
      #1;
      cycles++;
      if (cycles > 2000) begin
        abort_run({"timeout: spi_cs_n did not ", what});
      end
    end
  endtask

  task automatic spi_frame_test();
    spi_frame_t frame;
    spi_div_t   div;
    bus_data_t  lo;
    bus_data_t  hi;
    bus_data_t  ctrl;
    for (int n = 0; n < 4; n++) begin
      frame = {8'($random(seed)), 32'($random(seed))};
      div = spi_div_t'($unsigned($random(seed)) % 4);
      reg_write(io_addr(spi_tx_lower), frame[31:0]);
      reg_write(io_addr(spi_tx_upper), {24'h0, frame[39:32]});
      sck_rises = 0;
      reg_write(io_addr(spi_ctrl), {16'h0, div, 8'h01});
      wait_cs(1'b0, "fall after start");
      wait_cs(1'b1, "rise at end of frame");
      check_word(bus_data_t'(sck_rises), 32'd40, "sck rising edges per frame");
      reg_read(io_addr(spi_ctrl), ctrl);
      check_word(ctrl, {16'h0, div, 8'h00}, "spi_ctrl after frame");
      reg_read(io_addr(spi_rx_lower), lo);
      reg_read(io_addr(spi_rx_upper), hi);
      check_frame({hi[7:0], lo[31:0]}, frame, "loopback rx frame");
    end
  endtask

  task automatic step_move_test(input logic enabled);
    step_count_t  count;
    step_period_t period;
    step_period_t eff;
    logic         dir_bit;
    bus_data_t    got;
    int           cycles;
    int           limit;
    count = step_count_t'(1 + $unsigned($random(seed)) % 20);
    period = step_period_t'(2 + $unsigned($random(seed)) % 30);
    dir_bit = $random(seed);
    // periods below the minimum get clamped
    eff = (period < `STEPPER_PERIOD_MIN) ? step_period_t'(`STEPPER_PERIOD_MIN) : period;
    reg_write(io_addr(step_period), {16'h0, period});
    reg_write(io_addr(step_ctrl), {30'h0, enabled, dir_bit});
    check_word(bus_data_t'(dir), bus_data_t'(dir_bit), "dir pin");
    check_word(bus_data_t'(drv_en_n), bus_data_t'(!enabled), "drv_en_n pin");
    step_rises = 0;
    reg_write(io_addr(step_count), {16'h0, count});
    if (enabled) begin
      cycles = 0;
      limit = (count + 2) * eff + 20;
      while (step_rises < count) begin
        @(posedge clk_25mhz);
        #1;
        cycles++;
        if (step_rises == 0 && cycles > eff) begin
          abort_run("first step came later than one period after the load");
        end
        if (cycles > limit) begin
          abort_run("timeout: step count not reached");
        end
      end
    end
    // quiet window, catches extra pulses
    repeat (3 * eff) @(posedge clk_25mhz);
    #2;
    check_count(step_count_t'(step_rises), enabled ? count : 16'd0, "step rising edges");
    reg_read(io_addr(step_status), got);
    check_count(got[15:0], 16'd0, "remaining steps after move");
  endtask

  initial begin
    bus_data_t got;
    seed = 38578;
    clk_25mhz = 1'b0;
    rst_n = 1'b0;
    mem_valid = 1'b0;
    mem_addr = '0;
    mem_wdata = '0;
    mem_wstrb = '0;
    sck_rises = 0;
    step_rises = 0;
    sck_prev = 1'b0;
    step_prev = 1'b0;
    repeat (8) @(posedge clk_25mhz);
    #2;
    rst_n = 1'b1;

    // pins and status straight out of reset
    check_word(bus_data_t'(spi_cs_n), 32'd1, "spi_cs_n after reset");
    check_word(bus_data_t'(step), 32'd0, "step after reset");
    check_word(bus_data_t'(drv_en_n), 32'd1, "drv_en_n after reset");
    check_word(bus_data_t'(mem_ready), 32'd0, "mem_ready after reset");
    check_word(bus_data_t'(bus_fault), 32'd0, "bus_fault after reset");
    reg_read(io_addr(step_status), got);
    check_word(got, 32'h0, "step_status after reset");
    reg_read(io_addr(spi_ctrl), got);
    check_word(got, {16'h0, `STEPPER_SPI_DIV_RESET, 8'h00}, "spi_ctrl after reset");

    ram_fill();
    ram_random_test();
    unmapped_test();
    spi_frame_test();
    for (int n = 0; n < 4; n++) begin
      step_move_test(1'b1);
    end
    step_move_test(1'b0);

    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- stepper_top.f
+incdir+hw
hw/bus_pkg.sv
hw/motor_pkg.sv
hw/bus_decoder.sv
hw/sram.sv
hw/spi_master.sv
hw/step_generator.sv
hw/io_block.sv
hw/stepper_top.sv
tb/stepper_top_properties.sv
tb/stepper_tb.sv
